// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_snes_mem_ctrl
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+source
source/snes_bus_pkg.sv
source/mcu_arb_pkg.sv
source/snes_bus_if.sv
source/snes_bus_sync.sv
source/snes_alive_timer.sv
source/mcu_arb_fsm.sv
source/rom_port_mux.sv
source/snes_mem_ctrl.sv
tb/snes_mem_ctrl_props.sv
tb/tb_snes_mem_ctrl.sv

// File: source/mcu_arb_fsm.sv
`default_nettype none

`include "snes_mem_defs.svh"

module mcu_arb_fsm
  import snes_bus_pkg::*;
  import mcu_arb_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  snes_bus_if.arb    bus,
  input  logic       snes_dead,
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output logic       mcu_rdy,
  mcu_rom_if.fsm     rom
);

  localparam logic [`DELAY_W-1:0] cycle_len = `ROM_CYCLE_LEN;

  arb_state_e          state;
  logic [`DELAY_W-1:0] delay;
  logic                rd_pend;
  logic                wr_pend;
  logic                free_strobe;
  logic                free_slot;
  logic                end_state;
  mcu_op_e             pend_op;

  ////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////

  assign end_state = (state == st_mcu_rd_end) | (state == st_mcu_wr_end);

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin  // Read wins
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (end_state) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) begin
      rom.addr  <= mcu_addr;
      rom.wdata <= mcu_wdata;
    end
  end

  assign pend_op = rd_pend ? op_read : (wr_pend ? op_write : op_none);

  ////////////////////////////////////////
  // Free bus slots
  ////////////////////////////////////////

  // Cycle without ROM select leaves the port idle for its high phase
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & bus.romsel_n;
    end
  end

  assign free_slot = bus.cycle_end | free_strobe;

  ////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= st_idle;
      delay <= '0;
    end else if (snes_dead & bus.cpu_clk) begin
      state <= st_idle;  // Console woke up, drop the access and retry
    end else begin
      case (state)
        st_idle: begin
          if (free_slot | snes_dead) begin
            case (pend_op)
              op_read: begin
                state <= st_mcu_rd_addr;
                delay <= cycle_len;
              end
              op_write: begin
                state <= st_mcu_wr_addr;
                delay <= cycle_len;
              end
              op_none: state <= st_idle;
              default: state <= st_idle;
            endcase
          end
        end
        st_mcu_rd_addr, st_mcu_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= (state == st_mcu_rd_addr) ? st_mcu_rd_end : st_mcu_wr_end;
          end
        end
        st_mcu_rd_end, st_mcu_wr_end: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  assign rom.rd_active = (state == st_mcu_rd_addr);
  assign rom.wr_active = (state == st_mcu_wr_addr);

endmodule

`default_nettype wire

// File: source/mcu_arb_pkg.sv
`default_nettype none

package mcu_arb_pkg;

  // ROM access FSM
  typedef enum logic [2:0] {
    st_idle,
    st_mcu_rd_addr,  // MCU owns the ROM port, read
    st_mcu_rd_end,
    st_mcu_wr_addr,  // MCU owns the ROM port, write
    st_mcu_wr_end
  } arb_state_e;

  // Pending MCU operation
  typedef enum logic [1:0] {
    op_none,
    op_read,
    op_write
  } mcu_op_e;

endpackage

`default_nettype wire

// File: source/rom_port_mux.sv
`default_nettype none

module rom_port_mux
  import snes_bus_pkg::*;
(
  input  logic      CLK2,
  input  logic      reset,
  snes_bus_if.port  bus,
  mcu_rom_if.port   rom,
  input  rom_word_t rom_rdata,
  output rom_addr_t rom_addr,
  output rom_word_t rom_wdata,
  output logic      rom_we_n,
  output logic      rom_bhe_n,
  output logic      rom_ble_n,
  output byte_t     snes_data_out,
  output logic      snes_data_oe,
  output byte_t     mcu_rdata
);

  logic       mcu_hit;
  snes_addr_t eff_addr;
  logic       addr0;
  byte_t      lane_byte;

  ////////////////////////////////////////
  // Address and lanes
  ////////////////////////////////////////

  assign mcu_hit  = rom.rd_active | rom.wr_active;
  assign eff_addr = mcu_hit ? rom.addr : bus.addr;
  assign addr0    = eff_addr[0];

  assign rom_addr = eff_addr[23:1];  // Word address

  // Odd bytes live in the low lane
  assign rom_ble_n = ~addr0;
  assign rom_bhe_n = addr0;
  assign lane_byte = addr0 ? rom_rdata[7:0] : rom_rdata[15:8];

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  // Same byte on both lanes, the lane enable picks one
  assign rom_wdata = {rom.wdata, rom.wdata};
  assign rom_we_n  = ~rom.wr_active;

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  assign snes_data_out = lane_byte;
  assign snes_data_oe  = ~bus.read_n & ~bus.romsel_n & ~mcu_hit;

  // Last load before the end state holds the settled word
  always_ff @(posedge CLK2) begin
    if (reset) begin
      mcu_rdata <= '0;
    end else if (rom.rd_active) begin
      mcu_rdata <= lane_byte;
    end
  end

endmodule

`default_nettype wire

// File: source/snes_alive_timer.sv
`default_nettype none

`include "snes_mem_defs.svh"

module snes_alive_timer (
  input  logic      CLK2,
  input  logic      reset,
  snes_bus_if.timer bus,
  output logic      snes_dead
);

  localparam logic [`DEAD_CNT_W-1:0] dead_limit = `SNES_DEAD_TIMEOUT;

  logic [`DEAD_CNT_W-1:0] dead_cnt;  // CLK2 cycles since the clock was last high

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;  // No console until its clock shows up
    end else if (bus.cpu_clk) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      // Saturate so a long stop never wraps back under the limit
      if (~&dead_cnt) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      if (dead_cnt > dead_limit) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/snes_bus_if.sv
`default_nettype none

// Filtered console bus in the CLK2 domain
interface snes_bus_if
  import snes_bus_pkg::*;
();
  snes_addr_t addr;
  logic       read_n;
  logic       romsel_n;
  logic       cpu_clk;
  logic       cycle_start;  // One CLK2 pulse per CPU clock rise
  logic       cycle_end;    // One CLK2 pulse per CPU clock fall

  modport sync  (output addr, read_n, romsel_n, cpu_clk, cycle_start, cycle_end);
  modport arb   (input cycle_start, cycle_end, cpu_clk, romsel_n);
  modport timer (input cpu_clk);
  modport port  (input addr, read_n, romsel_n);
endinterface

// MCU access from the arbiter to the ROM port
interface mcu_rom_if
  import snes_bus_pkg::*;
();
  snes_addr_t addr;       // Latched MCU address
  byte_t      wdata;
  logic       rd_active;
  logic       wr_active;

  modport fsm  (output addr, wdata, rd_active, wr_active);
  modport port (input addr, wdata, rd_active, wr_active);
endinterface

`default_nettype wire

// File: source/snes_bus_pkg.sv
`default_nettype none

package snes_bus_pkg;

  ////////////////////////////////////////
  // Console side
  ////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Byte address, console or MCU
  typedef logic [7:0]  byte_t;

  ////////////////////////////////////////
  // ROM side
  ////////////////////////////////////////

  // 16-bit wide part, so the word address drops bit 0
  typedef logic [22:0] rom_addr_t;
  typedef logic [15:0] rom_word_t;

endpackage

`default_nettype wire

// File: source/snes_bus_sync.sv
`default_nettype none

`include "snes_mem_defs.svh"

module snes_bus_sync
  import snes_bus_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,
  input  snes_addr_t snes_addr,
  input  logic       snes_rd_n,
  input  logic       snes_romsel_n,
  input  logic       snes_cpu_clk,
  snes_bus_if.sync   bus
);

  // Width of the edge detection window
  localparam int ew = `SYNC_DEPTH - 2;
  localparam logic [ew-1:0] start_pat = ew'(3);
  localparam logic [ew-1:0] end_pat = {3'b111, {(ew - 3){1'b0}}};

  // Taps for the level outputs
  localparam int lvl_tap = 1;
  localparam int sel_tap = 4;  // Later, to line up with the address pipe
  localparam int addr_tap = `ADDR_SYNC_DEPTH - 2;

  logic [`SYNC_DEPTH-1:0] rd_sr;
  logic [`SYNC_DEPTH-1:0] romsel_sr;
  logic [`SYNC_DEPTH-1:0] clk_sr;
  snes_addr_t             addr_sr [`ADDR_SYNC_DEPTH];

  logic [ew-1:0] clk_and;
  logic [ew-1:0] clk_or;

  ////////////////////////////////////////
  // Input shift registers
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_sr     <= '1;  // Strobes idle high
      romsel_sr <= '1;
      clk_sr    <= '0;
    end else begin
      rd_sr     <= {rd_sr[`SYNC_DEPTH-2:0], snes_rd_n};
      romsel_sr <= {romsel_sr[`SYNC_DEPTH-2:0], snes_romsel_n};
      clk_sr    <= {clk_sr[`SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_sr[0] <= snes_addr;
    for (int i = 1; i < `ADDR_SYNC_DEPTH; i++) begin
      addr_sr[i] <= addr_sr[i-1];
    end
  end

  ////////////////////////////////////////
  // Glitch filter
  ////////////////////////////////////////

  // A level only counts once two stages agree
  assign bus.read_n   = rd_sr[lvl_tap+1] & rd_sr[lvl_tap];
  assign bus.cpu_clk  = clk_sr[lvl_tap+1] & clk_sr[lvl_tap];
  assign bus.romsel_n = romsel_sr[sel_tap+1] & romsel_sr[sel_tap];
  assign bus.addr     = addr_sr[addr_tap+1] & addr_sr[addr_tap];

  ////////////////////////////////////////
  // CPU clock edges
  ////////////////////////////////////////

  assign clk_and = clk_sr[`SYNC_DEPTH-1:2] & clk_sr[`SYNC_DEPTH-2:1];
  assign clk_or  = clk_sr[`SYNC_DEPTH-1:2] | clk_sr[`SYNC_DEPTH-2:1];

  // Rise after a stable low, seen high twice
  assign bus.cycle_start = (clk_and == start_pat);
  // Fall after a stable high
  assign bus.cycle_end   = (clk_or == end_pat);

endmodule

`default_nettype wire

// File: source/snes_mem_ctrl.sv
`default_nettype none

module snes_mem_ctrl
  import snes_bus_pkg::*;
(
  input  logic       CLK2,
  input  logic       reset,

  // Console
  input  snes_addr_t snes_addr,
  input  logic       snes_rd_n,
  input  logic       snes_romsel_n,
  input  logic       snes_cpu_clk,
  output byte_t      snes_data_out,
  output logic       snes_data_oe,

  // MCU
  input  logic       mcu_rrq,
  input  logic       mcu_wrq,
  input  snes_addr_t mcu_addr,
  input  byte_t      mcu_wdata,
  output logic       mcu_rdy,
  output byte_t      mcu_rdata,

  // External ROM
  input  rom_word_t  rom_rdata,
  output rom_addr_t  rom_addr,
  output rom_word_t  rom_wdata,
  output logic       rom_we_n,
  output logic       rom_bhe_n,
  output logic       rom_ble_n
);

  logic snes_dead;

  snes_bus_if bus_if ();
  mcu_rom_if  rom_if ();

  ////////////////////////////////////////
  // Console side
  ////////////////////////////////////////

  snes_bus_sync u_sync (
    .CLK2          (CLK2),
    .reset         (reset),
    .snes_addr     (snes_addr),
    .snes_rd_n     (snes_rd_n),
    .snes_romsel_n (snes_romsel_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .bus           (bus_if.sync)
  );

  snes_alive_timer u_alive (
    .CLK2      (CLK2),
    .reset     (reset),
    .bus       (bus_if.timer),
    .snes_dead (snes_dead)
  );

  ////////////////////////////////////////
  // Arbitration and ROM port
  ////////////////////////////////////////

  mcu_arb_fsm u_arb (
    .CLK2      (CLK2),
    .reset     (reset),
    .bus       (bus_if.arb),
    .snes_dead (snes_dead),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rdy   (mcu_rdy),
    .rom       (rom_if.fsm)
  );

  rom_port_mux u_rom_port (
    .CLK2          (CLK2),
    .reset         (reset),
    .bus           (bus_if.port),
    .rom           (rom_if.port),
    .rom_rdata     (rom_rdata),
    .rom_addr      (rom_addr),
    .rom_wdata     (rom_wdata),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .mcu_rdata     (mcu_rdata)
  );

endmodule

`default_nettype wire

// File: source/snes_mem_defs.svh
`ifndef SNES_MEM_DEFS_SVH
`define SNES_MEM_DEFS_SVH

// Delay count loaded when an MCU access starts
`define ROM_CYCLE_LEN 7
`define DELAY_W 4

// CLK2 cycles of low CPU clock, about 1 ms
`define SNES_DEAD_TIMEOUT 96000
`define DEAD_CNT_W 18

// Synchroniser depths
`define SYNC_DEPTH 8
`define ADDR_SYNC_DEPTH 7

`endif

// File: tb/snes_mem_ctrl_props.sv
`default_nettype none

`include "snes_mem_defs.svh"

module snes_mem_ctrl_props (
  input wire logic CLK2,
  input wire logic reset,
  input wire logic mcu_rrq,
  input wire logic mcu_wrq,
  input wire logic mcu_rdy,
  input wire logic rom_we_n,
  input wire logic rom_bhe_n,
  input wire logic rom_ble_n,
  input wire logic snes_data_oe
);

  // ROM write never overlaps a console read
  a_no_we_while_oe : assert property (@(posedge CLK2) disable iff (reset)
    !(!rom_we_n && snes_data_oe))
    else $error("rom_we_n low while snes_data_oe high");

  // Ready drops after a request
  a_rdy_drops : assert property (@(posedge CLK2) disable iff (reset)
    (mcu_rrq || mcu_wrq) |=> !mcu_rdy)
    else $error("mcu_rdy did not drop after a request");

  // Ready stays low for at least the shortest access
  a_rdy_low_in_access : assert property (@(posedge CLK2) disable iff (reset)
    $rose(mcu_rdy) |-> !$past(mcu_rdy, `ROM_CYCLE_LEN + 3))
    else $error("mcu_rdy rose before the access could end");

  a_one_lane : assert property (@(posedge CLK2) disable iff (reset)
    !(!rom_bhe_n && !rom_ble_n))
    else $error("both byte lanes enabled");

endmodule

bind snes_mem_ctrl snes_mem_ctrl_props u_props (
  .CLK2         (CLK2),
  .reset        (reset),
  .mcu_rrq      (mcu_rrq),
  .mcu_wrq      (mcu_wrq),
  .mcu_rdy      (mcu_rdy),
  .rom_we_n     (rom_we_n),
  .rom_bhe_n    (rom_bhe_n),
  .rom_ble_n    (rom_ble_n),
  .snes_data_oe (snes_data_oe)
);

`default_nettype wire

// File: tb/tb_snes_mem_ctrl.sv
`default_nettype none

`include "snes_mem_defs.svh"

module tb_snes_mem_ctrl
  import snes_bus_pkg::*;
  import mcu_arb_pkg::*;
();

  logic       CLK2 = 1'b0;
  logic       reset;
  snes_addr_t snes_addr;
  logic       snes_rd_n;
  logic       snes_romsel_n;
  logic       snes_cpu_clk;
  byte_t      snes_data_out;
  logic       snes_data_oe;
  logic       mcu_rrq;
  logic       mcu_wrq;
  snes_addr_t mcu_addr;
  byte_t      mcu_wdata;
  logic       mcu_rdy;
  byte_t      mcu_rdata;
  rom_word_t  rom_rdata = '0;
  rom_addr_t  rom_addr;
  rom_word_t  rom_wdata;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;

  logic [31:0] rnd_state = 32'hd3a9_5271;
  byte_t       written [snes_addr_t];  // Bytes written by the MCU
  int          wr_count = 0;
  mcu_op_e     seen_op = op_none;
  logic        clk_run = 1'b0;         // Console clock enable
  int          cpu_div = 0;

  snes_mem_ctrl UUT (.*);

  always #10 CLK2 = ~CLK2;

  ////////////////////////////////////////
  // Random numbers and ROM model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = lcg_step(rnd_state);
    return rnd_state;
  endfunction

  // Byte at a console address, odd bytes in the low lane
  function automatic byte_t model_byte(input snes_addr_t a);
    logic [31:0] h;
    if (written.exists(a)) begin
      return written[a];
    end
    h = lcg_step(lcg_step(32'hd3a9_5271 ^ {8'h00, a[23:1], 1'b0}));
    return a[0] ? h[15:8] : h[23:16];
  endfunction

  always @(rom_addr or wr_count) begin
    rom_rdata = {model_byte({rom_addr, 1'b0}), model_byte({rom_addr, 1'b1})};
  end

  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      if (!rom_ble_n) written[{rom_addr, 1'b1}] = rom_wdata[7:0];
      if (!rom_bhe_n) written[{rom_addr, 1'b0}] = rom_wdata[15:8];
      seen_op <= op_write;
      wr_count <= wr_count + 1;
    end
  end

  // Console CPU clock, 12 CLK2 cycles per period
  always @(posedge CLK2) begin
    #2;
    if (clk_run) begin
      cpu_div = (cpu_div == 5) ? 0 : cpu_div + 1;
      if (cpu_div == 0) snes_cpu_clk = ~snes_cpu_clk;
    end else begin
      snes_cpu_clk = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_rom_addr(input rom_addr_t got, input rom_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: rom_addr got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_word(input string what, input rom_word_t got, input rom_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_op(input mcu_op_e got, input mcu_op_e exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: ROM port op got %s expected %s",
                         $time, got.name(), exp.name()));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic mcu_request(input mcu_op_e op, input snes_addr_t a, input byte_t d);
    @(posedge CLK2);
    #2;
    check_level("mcu_rdy before request", mcu_rdy, 1'b1);
    seen_op   <= op_none;
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_rrq   = (op == op_read);
    mcu_wrq   = (op == op_write);
    @(posedge CLK2);
    #2;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
  endtask

  task automatic wait_rdy(input int max_cycles);
    int n;
    n = 0;
    @(negedge CLK2);
    while (!mcu_rdy) begin
      if (n == max_cycles) stop_run("Timeout waiting for mcu_rdy to rise");
      n++;
      @(negedge CLK2);
    end
  endtask

  task automatic mcu_read_check(input snes_addr_t a, input int max_cycles);
    byte_t exp;
    exp = model_byte(a);
    mcu_request(op_read, a, 8'h00);
    wait_rdy(max_cycles);
    check_byte("mcu_rdata", mcu_rdata, exp);
    check_op(seen_op, op_none);  // A read must not write
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_values();
    @(negedge CLK2);
    check_level("mcu_rdy after reset", mcu_rdy, 1'b1);
    check_level("rom_we_n after reset", rom_we_n, 1'b1);
    check_level("snes_data_oe after reset", snes_data_oe, 1'b0);
  endtask

  task automatic dead_write_then_read();
    snes_addr_t wa;
    snes_addr_t ra;
    byte_t      d;
    int         n;
    wa = snes_addr_t'(next_rand()) | 24'h1;  // Odd, low lane
    d  = byte_t'(next_rand());
    mcu_request(op_write, wa, d);
    n = 0;
    @(negedge CLK2);
    while (rom_we_n) begin
      if (n == 100) stop_run("Timeout waiting for the MCU write on the ROM port");
      n++;
      @(negedge CLK2);
    end
    check_rom_addr(rom_addr, wa[23:1]);
    check_level("rom_ble_n", rom_ble_n, 1'b0);
    check_level("rom_bhe_n", rom_bhe_n, 1'b1);
    check_word("rom_wdata", rom_wdata, {d, d});
    wait_rdy(100);
    check_op(seen_op, op_write);
    ra = snes_addr_t'(next_rand()) & 24'hff_fffe;  // Even, high lane
    mcu_read_check(ra, 100);
    mcu_read_check(wa, 100);
  endtask

  task automatic console_rom_read();
    snes_addr_t a;
    clk_run = 1'b1;
    repeat (40) @(posedge CLK2);
    #2;
    a = snes_addr_t'(next_rand());
    snes_addr     = a;
    snes_romsel_n = 1'b0;
    snes_rd_n     = 1'b0;
    repeat (12) @(posedge CLK2);
    @(negedge CLK2);
    check_level("snes_data_oe", snes_data_oe, 1'b1);
    check_byte("snes_data_out", snes_data_out, model_byte(a));
    @(posedge CLK2);
    #2;
    snes_romsel_n = 1'b1;
    snes_rd_n     = 1'b1;
    repeat (12) @(posedge CLK2);
  endtask

  task automatic running_mcu_read();
    mcu_read_check(snes_addr_t'(next_rand()), 200);
    mcu_read_check(snes_addr_t'(next_rand()), 200);
  endtask

  task automatic dead_timeout_write();
    snes_addr_t a;
    byte_t      d;
    clk_run = 1'b0;
    repeat (30) @(posedge CLK2);  // Let the last cycle edges pass
    a = snes_addr_t'(next_rand()) & 24'hff_fffe;
    d = byte_t'(next_rand());
    mcu_request(op_write, a, d);
    repeat (`SNES_DEAD_TIMEOUT / 2) @(posedge CLK2);
    @(negedge CLK2);
    check_level("mcu_rdy at half timeout", mcu_rdy, 1'b0);
    check_op(seen_op, op_none);
    wait_rdy(`SNES_DEAD_TIMEOUT);
    check_op(seen_op, op_write);
    check_byte("written byte", model_byte(a), d);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    reset         = 1'b1;
    snes_addr     = '0;
    snes_rd_n     = 1'b1;
    snes_romsel_n = 1'b1;
    snes_cpu_clk  = 1'b0;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    repeat (8) @(posedge CLK2);
    #2;
    reset = 1'b0;
    reset_values();
    dead_write_then_read();
    console_rom_read();
    running_mcu_read();
    dead_timeout_write();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(3 * (`SNES_DEAD_TIMEOUT + 2000) * 20);
    stop_run("Watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire
